/* common/rvviPkg.sv */
// RV32 only; the cause codes assume the core's RVFI encoding and CSRs are positional
package rvviPkg;

   ////////////////////////////////////////////////////////////
   // Field widths of the retirement trace
   ////////////////////////////////////////////////////////////
   typedef logic [31:0] xlenT;
   typedef logic [63:0] orderT;
   typedef logic [4:0]  regAddrT;
   typedef logic [5:0]  excCauseT;
   typedef logic [10:0] intrCauseT;
   typedef logic [2:0]  dbgCauseT;
   typedef logic [1:0]  privModeT;

   ////////////////////////////////////////////////////////////
   // Trace constants
   ////////////////////////////////////////////////////////////

   // Instruction bus fault, the only trap raised from outside the core
   localparam excCauseT FETCH_FAULT_CAUSE = 6'd48;

   // Load and store bus errors reported as NMI
   localparam intrCauseT NMI_LOAD_CAUSE  = 11'd1024;
   localparam intrCauseT NMI_STORE_CAUSE = 11'd1025;

   // Debug entry caused by an external halt request
   localparam dbgCauseT DBG_CAUSE_HALTREQ = 3'd3;

   localparam int NUM_GPR = 32;

endpackage

/* common/retireIf.sv */
// One accepted retirement per valid strobe; fields hold until the next one and there is no back-pressure
`timescale 1ns/1ps

interface retireIf import rvviPkg::*; #(
   parameter int NUM_CSR = 8
) ();

   // Strobe for one cycle per accepted retirement
   logic valid;

   // Instruction record
   orderT    order;
   xlenT     insn;
   xlenT     pcRdata;
   xlenT     pcWdata;
   privModeT mode;

   // Trap and interrupt causes
   logic      trap;
   logic      trapException;
   excCauseT  excCause;
   logic      intr;
   logic      intrInterrupt;
   intrCauseT intrCause;

   // Debug and NMI state
   dbgCauseT dbgCause;
   logic     dbgMode;
   logic     nmiPending;

   // Destination register write
   regAddrT rdAddr;
   xlenT    rdWdata;

   // CSR trace, one word per tracked CSR
   xlenT [NUM_CSR-1:0] csrRdata;
   xlenT [NUM_CSR-1:0] csrWdata;
   xlenT [NUM_CSR-1:0] csrWmask;

   modport capture (
      output valid, order, insn, pcRdata, pcWdata, mode,
      output trap, trapException, excCause, intr, intrInterrupt, intrCause,
      output dbgCause, dbgMode, nmiPending, rdAddr, rdWdata,
      output csrRdata, csrWdata, csrWmask
   );

   modport sink (
      input valid, order, insn, pcRdata, pcWdata, mode,
      input trap, trapException, excCause, intr, intrInterrupt, intrCause,
      input dbgCause, dbgMode, nmiPending, rdAddr, rdWdata,
      input csrRdata, csrWdata, csrWmask
   );

endinterface

/* verilog/rvfiCapture.sv */
// Repeated order numbers are dropped and the first valid after reset is always taken
`timescale 1ns/1ps

module rvfiCapture import rvviPkg::*; #(
   parameter int NUM_CSR = 8,
   parameter int NUM_IRQ = 32
) (
   input  logic               rvvi,
   input  logic               arstN_i,
   input  logic               rvfiValid_i,
   input  orderT              rvfiOrder_i,
   input  xlenT               rvfiInsn_i,
   input  xlenT               rvfiPcRdata_i,
   input  xlenT               rvfiPcWdata_i,
   input  privModeT           rvfiMode_i,
   input  logic               rvfiTrap_i,
   input  logic               rvfiTrapException_i,
   input  excCauseT           rvfiExcCause_i,
   input  logic               rvfiIntr_i,
   input  logic               rvfiIntrInterrupt_i,
   input  intrCauseT          rvfiIntrCause_i,
   input  dbgCauseT           rvfiDbgCause_i,
   input  logic               rvfiDbgMode_i,
   input  logic               rvfiNmiPending_i,
   input  regAddrT            rvfiRdAddr_i,
   input  xlenT               rvfiRdWdata_i,
   input  xlenT [NUM_CSR-1:0] csrRdata_i,
   input  xlenT [NUM_CSR-1:0] csrWdata_i,
   input  xlenT [NUM_CSR-1:0] csrWmask_i,
   input  logic [NUM_IRQ-1:0] irq_i,
   retireIf.capture           retire,
   output logic [NUM_IRQ-1:0] irqLevel_o
);

   logic seenOne;
   logic accept;

   // The captured order doubles as the last accepted order number
   assign accept = rvfiValid_i && (!seenOne || (rvfiOrder_i != retire.order));

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         seenOne              <= 1'b0;
         retire.valid         <= 1'b0;
         retire.order         <= '0;
         retire.insn          <= '0;
         retire.pcRdata       <= '0;
         retire.pcWdata       <= '0;
         retire.mode          <= '0;
         retire.trap          <= 1'b0;
         retire.trapException <= 1'b0;
         retire.excCause      <= '0;
         retire.intr          <= 1'b0;
         retire.intrInterrupt <= 1'b0;
         retire.intrCause     <= '0;
         retire.dbgCause      <= '0;
         retire.dbgMode       <= 1'b0;
         retire.nmiPending    <= 1'b0;
         retire.rdAddr        <= '0;
         retire.rdWdata       <= '0;
         retire.csrRdata      <= '0;
         retire.csrWdata      <= '0;
         retire.csrWmask      <= '0;
      end else begin
         retire.valid <= accept;
         if (accept) begin
            seenOne              <= 1'b1;
            retire.order         <= rvfiOrder_i;
            retire.insn          <= rvfiInsn_i;
            retire.pcRdata       <= rvfiPcRdata_i;
            retire.pcWdata       <= rvfiPcWdata_i;
            retire.mode          <= rvfiMode_i;
            retire.trap          <= rvfiTrap_i;
            retire.trapException <= rvfiTrapException_i;
            retire.excCause      <= rvfiExcCause_i;
            retire.intr          <= rvfiIntr_i;
            retire.intrInterrupt <= rvfiIntrInterrupt_i;
            retire.intrCause     <= rvfiIntrCause_i;
            retire.dbgCause      <= rvfiDbgCause_i;
            retire.dbgMode       <= rvfiDbgMode_i;
            retire.nmiPending    <= rvfiNmiPending_i;
            retire.rdAddr        <= rvfiRdAddr_i;
            retire.rdWdata       <= rvfiRdWdata_i;
            retire.csrRdata      <= csrRdata_i;
            retire.csrWdata      <= csrWdata_i;
            retire.csrWmask      <= csrWmask_i;
         end
      end
   end

   // Interrupt lines are sampled every cycle, independent of retirement
   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         irqLevel_o <= '0;
      end else begin
         irqLevel_o <= irq_i;
      end
   end

endmodule

/* csrTrack/csrMerge.sv */
// CSRs are positional; change flags compare with the last retirement and start from zero after reset
`timescale 1ns/1ps

module csrMerge import rvviPkg::*; #(
   parameter int NUM_CSR = 8
) (
   input  logic               rvvi,
   input  logic               arstN_i,
   retireIf.sink              retire,
   output xlenT [NUM_CSR-1:0] csrValue_o,
   output logic [NUM_CSR-1:0] csrWb_o
);

   xlenT [NUM_CSR-1:0] merged;
   xlenT [NUM_CSR-1:0] prevValue;

   ////////////////////////////////////////////////////////////
   // Merge and compare
   ////////////////////////////////////////////////////////////

   // Written bits come from wdata, the rest keep the read value
   always_comb begin
      for (int i = 0; i < NUM_CSR; i++) begin
         merged[i]  = (retire.csrWdata[i] & retire.csrWmask[i]) |
                      (retire.csrRdata[i] & ~retire.csrWmask[i]);
         csrWb_o[i] = (merged[i] != prevValue[i]);
      end
   end

   assign csrValue_o = merged;

   ////////////////////////////////////////////////////////////
   // Value seen at the previous retirement
   ////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         prevValue <= '0;
      end else if (retire.valid) begin
         prevValue <= merged;
      end
   end

endmodule

/* verilog/faultEvents.sv */
// Net levels move only at retirements, so a halt request between retirements is not seen
`timescale 1ns/1ps

module faultEvents import rvviPkg::*; (
   input  logic      rvvi,
   input  logic      arstN_i,
   retireIf.sink     retire,
   output logic      haltReq_o,
   output logic      nmi_o,
   output intrCauseT nmiCause_o,
   output logic      fetchFault_o
);

   logic nmiHit;
   logic faultHit;
   logic haltHit;

   // Bus error NMI, either taken now or still pending
   assign nmiHit = (retire.intr && retire.intrInterrupt &&
                    ((retire.intrCause == NMI_LOAD_CAUSE) ||
                     (retire.intrCause == NMI_STORE_CAUSE))) ||
                   retire.nmiPending;

   // Instruction fetch fault trap
   assign faultHit = retire.trap && retire.trapException &&
                     (retire.excCause == FETCH_FAULT_CAUSE);

   // Debug entry from an external halt request
   assign haltHit = (retire.dbgCause == DBG_CAUSE_HALTREQ) && retire.dbgMode;

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         haltReq_o    <= 1'b0;
         nmi_o        <= 1'b0;
         nmiCause_o   <= '0;
         fetchFault_o <= 1'b0;
      end else if (retire.valid) begin
         haltReq_o    <= haltHit;
         nmi_o        <= nmiHit;
         fetchFault_o <= faultHit;
         // Cause is held once the NMI drops
         if (nmiHit) begin
            nmiCause_o <= retire.intrCause;
         end
      end
   end

endmodule

/* verilog/rvviOutput.sv */
// Record trails the capture stage by one edge; net levels arrive already aligned with it
`timescale 1ns/1ps

module rvviOutput import rvviPkg::*; #(
   parameter int NUM_CSR = 8,
   parameter int NUM_IRQ = 32
) (
   input  logic               rvvi,
   input  logic               arstN_i,
   retireIf.sink              retire,
   input  xlenT [NUM_CSR-1:0] csrValue_i,
   input  logic [NUM_CSR-1:0] csrWb_i,
   input  logic               haltReq_i,
   input  logic               nmi_i,
   input  intrCauseT          nmiCause_i,
   input  logic               fetchFault_i,
   input  logic [NUM_IRQ-1:0] irqLevel_i,
   output logic               rvviValid_o,
   output orderT              rvviOrder_o,
   output xlenT               rvviInsn_o,
   output xlenT               rvviPcRdata_o,
   output xlenT               rvviPcWdata_o,
   output privModeT           rvviMode_o,
   output logic               rvviTrap_o,
   output logic               rvviIntr_o,
   output logic [NUM_GPR-1:0] xWb_o,
   output xlenT               xWdata_o,
   output xlenT [NUM_CSR-1:0] csrValue_o,
   output logic [NUM_CSR-1:0] csrWb_o,
   output logic               haltReq_o,
   output logic               nmi_o,
   output intrCauseT          nmiCause_o,
   output logic               fetchFault_o,
   output logic [NUM_IRQ-1:0] irqLevel_o,
   output logic [3:0]         netChange_o,
   output logic [NUM_IRQ-1:0] irqChange_o
);

   logic               haltPrev;
   logic               nmiPrev;
   intrCauseT          nmiCausePrev;
   logic               faultPrev;
   logic [NUM_IRQ-1:0] irqPrev;

   ////////////////////////////////////////////////////////////
   // Retirement record
   ////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         rvviValid_o   <= 1'b0;
         rvviOrder_o   <= '0;
         rvviInsn_o    <= '0;
         rvviPcRdata_o <= '0;
         rvviPcWdata_o <= '0;
         rvviMode_o    <= '0;
         rvviTrap_o    <= 1'b0;
         rvviIntr_o    <= 1'b0;
         xWb_o         <= '0;
         xWdata_o      <= '0;
         csrValue_o    <= '0;
         csrWb_o       <= '0;
      end else begin
         rvviValid_o <= retire.valid;
         if (retire.valid) begin
            rvviOrder_o   <= retire.order;
            rvviInsn_o    <= retire.insn;
            rvviPcRdata_o <= retire.pcRdata;
            rvviPcWdata_o <= retire.pcWdata;
            rvviMode_o    <= retire.mode;
            // Only the externally raised fetch trap is flagged
            rvviTrap_o    <= retire.trap && (retire.excCause == FETCH_FAULT_CAUSE);
            rvviIntr_o    <= retire.intr;
            // x0 is never reported as written
            xWb_o         <= (retire.rdAddr == '0) ? '0 : NUM_GPR'(1) << retire.rdAddr;
            xWdata_o      <= retire.rdWdata;
            csrValue_o    <= csrValue_i;
            csrWb_o       <= csrWb_i;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Nets and change strobes
   ////////////////////////////////////////////////////////////
   assign haltReq_o    = haltReq_i;
   assign nmi_o        = nmi_i;
   assign nmiCause_o   = nmiCause_i;
   assign fetchFault_o = fetchFault_i;

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         haltPrev     <= 1'b0;
         nmiPrev      <= 1'b0;
         nmiCausePrev <= '0;
         faultPrev    <= 1'b0;
         irqLevel_o   <= '0;
         irqPrev      <= '0;
      end else begin
         haltPrev     <= haltReq_i;
         nmiPrev      <= nmi_i;
         nmiCausePrev <= nmiCause_i;
         faultPrev    <= fetchFault_i;
         irqLevel_o   <= irqLevel_i;
         irqPrev      <= irqLevel_o;
      end
   end

   // Bit 3 halt, bit 2 NMI, bit 1 NMI cause, bit 0 fetch fault
   assign netChange_o = {haltReq_i ^ haltPrev,
                         nmi_i ^ nmiPrev,
                         nmiCause_i != nmiCausePrev,
                         fetchFault_i ^ faultPrev};

   assign irqChange_o = irqLevel_o ^ irqPrev;

endmodule

/* verilog/rvviBridge.sv */
// Every output trails acceptance by two edges; one hart, no CLIC and no back-pressure
`timescale 1ns/1ps

module rvviBridge import rvviPkg::*; #(
   parameter int NUM_CSR = 8,
   parameter int NUM_IRQ = 32
) (
   input  logic               rvvi,
   input  logic               arstN_i,
   input  logic               rvfiValid_i,
   input  orderT              rvfiOrder_i,
   input  xlenT               rvfiInsn_i,
   input  xlenT               rvfiPcRdata_i,
   input  xlenT               rvfiPcWdata_i,
   input  privModeT           rvfiMode_i,
   input  logic               rvfiTrap_i,
   input  logic               rvfiTrapException_i,
   input  excCauseT           rvfiExcCause_i,
   input  logic               rvfiIntr_i,
   input  logic               rvfiIntrInterrupt_i,
   input  intrCauseT          rvfiIntrCause_i,
   input  dbgCauseT           rvfiDbgCause_i,
   input  logic               rvfiDbgMode_i,
   input  logic               rvfiNmiPending_i,
   input  regAddrT            rvfiRdAddr_i,
   input  xlenT               rvfiRdWdata_i,
   input  xlenT [NUM_CSR-1:0] csrRdata_i,
   input  xlenT [NUM_CSR-1:0] csrWdata_i,
   input  xlenT [NUM_CSR-1:0] csrWmask_i,
   input  logic [NUM_IRQ-1:0] irq_i,
   output logic               rvviValid_o,
   output orderT              rvviOrder_o,
   output xlenT               rvviInsn_o,
   output xlenT               rvviPcRdata_o,
   output xlenT               rvviPcWdata_o,
   output privModeT           rvviMode_o,
   output logic               rvviTrap_o,
   output logic               rvviIntr_o,
   output logic [NUM_GPR-1:0] xWb_o,
   output xlenT               xWdata_o,
   output xlenT [NUM_CSR-1:0] csrValue_o,
   output logic [NUM_CSR-1:0] csrWb_o,
   output logic               haltReq_o,
   output logic               nmi_o,
   output intrCauseT          nmiCause_o,
   output logic               fetchFault_o,
   output logic [NUM_IRQ-1:0] irqLevel_o,
   output logic [3:0]         netChange_o,
   output logic [NUM_IRQ-1:0] irqChange_o
);

   xlenT [NUM_CSR-1:0] csrValue;
   logic [NUM_CSR-1:0] csrWb;
   logic               haltReq;
   logic               nmi;
   intrCauseT          nmiCause;
   logic               fetchFault;
   logic [NUM_IRQ-1:0] irqLevel;

   retireIf #(.NUM_CSR(NUM_CSR)) retire ();

   rvfiCapture #(.NUM_CSR(NUM_CSR), .NUM_IRQ(NUM_IRQ)) i_rvfiCapture (
      .rvvi                (rvvi),
      .arstN_i             (arstN_i),
      .rvfiValid_i         (rvfiValid_i),
      .rvfiOrder_i         (rvfiOrder_i),
      .rvfiInsn_i          (rvfiInsn_i),
      .rvfiPcRdata_i       (rvfiPcRdata_i),
      .rvfiPcWdata_i       (rvfiPcWdata_i),
      .rvfiMode_i          (rvfiMode_i),
      .rvfiTrap_i          (rvfiTrap_i),
      .rvfiTrapException_i (rvfiTrapException_i),
      .rvfiExcCause_i      (rvfiExcCause_i),
      .rvfiIntr_i          (rvfiIntr_i),
      .rvfiIntrInterrupt_i (rvfiIntrInterrupt_i),
      .rvfiIntrCause_i     (rvfiIntrCause_i),
      .rvfiDbgCause_i      (rvfiDbgCause_i),
      .rvfiDbgMode_i       (rvfiDbgMode_i),
      .rvfiNmiPending_i    (rvfiNmiPending_i),
      .rvfiRdAddr_i        (rvfiRdAddr_i),
      .rvfiRdWdata_i       (rvfiRdWdata_i),
      .csrRdata_i          (csrRdata_i),
      .csrWdata_i          (csrWdata_i),
      .csrWmask_i          (csrWmask_i),
      .irq_i               (irq_i),
      .retire              (retire.capture),
      .irqLevel_o          (irqLevel)
   );

   csrMerge #(.NUM_CSR(NUM_CSR)) i_csrMerge (
      .rvvi       (rvvi),
      .arstN_i    (arstN_i),
      .retire     (retire.sink),
      .csrValue_o (csrValue),
      .csrWb_o    (csrWb)
   );

   faultEvents i_faultEvents (
      .rvvi         (rvvi),
      .arstN_i      (arstN_i),
      .retire       (retire.sink),
      .haltReq_o    (haltReq),
      .nmi_o        (nmi),
      .nmiCause_o   (nmiCause),
      .fetchFault_o (fetchFault)
   );

   rvviOutput #(.NUM_CSR(NUM_CSR), .NUM_IRQ(NUM_IRQ)) i_rvviOutput (
      .rvvi          (rvvi),
      .arstN_i       (arstN_i),
      .retire        (retire.sink),
      .csrValue_i    (csrValue),
      .csrWb_i       (csrWb),
      .haltReq_i     (haltReq),
      .nmi_i         (nmi),
      .nmiCause_i    (nmiCause),
      .fetchFault_i  (fetchFault),
      .irqLevel_i    (irqLevel),
      .rvviValid_o   (rvviValid_o),
      .rvviOrder_o   (rvviOrder_o),
      .rvviInsn_o    (rvviInsn_o),
      .rvviPcRdata_o (rvviPcRdata_o),
      .rvviPcWdata_o (rvviPcWdata_o),
      .rvviMode_o    (rvviMode_o),
      .rvviTrap_o    (rvviTrap_o),
      .rvviIntr_o    (rvviIntr_o),
      .xWb_o         (xWb_o),
      .xWdata_o      (xWdata_o),
      .csrValue_o    (csrValue_o),
      .csrWb_o       (csrWb_o),
      .haltReq_o     (haltReq_o),
      .nmi_o         (nmi_o),
      .nmiCause_o    (nmiCause_o),
      .fetchFault_o  (fetchFault_o),
      .irqLevel_o    (irqLevel_o),
      .netChange_o   (netChange_o),
      .irqChange_o   (irqChange_o)
   );

endmodule

/* tb/rvviModel.svh */
// Model of the bridge; include inside the testbench module after its DUT signals; CSRs are positional
`ifndef RVVI_MODEL_SVH
`define RVVI_MODEL_SVH

// One expected RVVI record and the active edge it is due after
typedef struct {
   int                 dueEdge;
   orderT              order;
   xlenT               insn;
   xlenT               pcRdata;
   xlenT               pcWdata;
   privModeT           mode;
   logic               trap;
   logic               intr;
   logic [NUM_GPR-1:0] xWb;
   xlenT               xWdata;
   xlenT [NUM_CSR-1:0] csrValue;
   logic [NUM_CSR-1:0] csrWb;
   logic               halt;
   logic               nmi;
   intrCauseT          intrCause;
   logic               fault;
} expRecT;

expRecT             recQ[$];
expRecT             curRec;
int                 edgeCnt = 0;
int                 recCount = 0;
logic               seenAny = 1'b0;
orderT              lastOrder = '0;
xlenT [NUM_CSR-1:0] prevCsr = '0;
logic               expValid = 1'b0;

// Net levels after the current edge and after the one before
logic               expHalt = 1'b0;
logic               expNmi = 1'b0;
logic               expFault = 1'b0;
intrCauseT          expNmiCause = '0;
logic               prevHalt = 1'b0;
logic               prevNmi = 1'b0;
logic               prevFault = 1'b0;
intrCauseT          prevCause = '0;

// Interrupt lines one and two edges old
logic [NUM_IRQ-1:0] irqD1 = '0;
logic [NUM_IRQ-1:0] expIrq = '0;
logic [NUM_IRQ-1:0] expIrqPrev = '0;

// Advance the model by one active rising edge, using the inputs seen at that edge
task automatic modelEdge();
   expRecT rec;
   prevHalt   = expHalt;
   prevNmi    = expNmi;
   prevCause  = expNmiCause;
   prevFault  = expFault;
   expIrqPrev = expIrq;
   expIrq     = irqD1;
   irqD1      = irq_i;
   expValid   = 1'b0;

   // Record accepted one edge ago shows up now, together with its nets
   if (recQ.size() > 0 && recQ[0].dueEdge == edgeCnt) begin
      curRec   = recQ.pop_front();
      expValid = 1'b1;
      expHalt  = curRec.halt;
      expNmi   = curRec.nmi;
      expFault = curRec.fault;
      if (curRec.nmi) begin
         expNmiCause = curRec.intrCause;
      end
   end

   // New order number, or the first valid since reset
   if (rvfiValid_i && (!seenAny || rvfiOrder_i != lastOrder)) begin
      seenAny     = 1'b1;
      lastOrder   = rvfiOrder_i;
      rec.dueEdge = edgeCnt + 1;
      rec.order   = rvfiOrder_i;
      rec.insn    = rvfiInsn_i;
      rec.pcRdata = rvfiPcRdata_i;
      rec.pcWdata = rvfiPcWdata_i;
      rec.mode    = rvfiMode_i;
      rec.trap    = rvfiTrap_i && (rvfiExcCause_i == 6'd48);
      rec.intr    = rvfiIntr_i;
      rec.xWb     = '0;
      if (rvfiRdAddr_i != 5'd0) begin
         rec.xWb[rvfiRdAddr_i] = 1'b1;
      end
      rec.xWdata = rvfiRdWdata_i;
      // Each written bit takes wdata, every other bit keeps rdata
      for (int i = 0; i < NUM_CSR; i++) begin
         for (int b = 0; b < $bits(xlenT); b++) begin
            rec.csrValue[i][b] = csrWmask_i[i][b] ? csrWdata_i[i][b] : csrRdata_i[i][b];
         end
         rec.csrWb[i] = (rec.csrValue[i] != prevCsr[i]);
      end
      prevCsr       = rec.csrValue;
      rec.halt      = (rvfiDbgCause_i == 3'd3) && rvfiDbgMode_i;
      rec.nmi       = (rvfiIntr_i && rvfiIntrInterrupt_i &&
                       (rvfiIntrCause_i == 11'd1024 || rvfiIntrCause_i == 11'd1025)) ||
                      rvfiNmiPending_i;
      rec.intrCause = rvfiIntrCause_i;
      rec.fault     = rvfiTrap_i && rvfiTrapException_i && (rvfiExcCause_i == 6'd48);
      recQ.push_back(rec);
      recCount++;
   end
   edgeCnt++;
endtask

`endif

/* tb/tbRvviBridge.sv */
// Self-checking testbench for the bridge with 8 CSRs and 32 interrupt lines; fixed random seed
`timescale 1ns/1ps

module tbRvviBridge import rvviPkg::*; ();

   localparam int NUM_CSR   = 8;
   localparam int NUM_IRQ   = 32;
   localparam int NUM_ITER  = 3000;
   localparam int DRAIN_MAX = 20;

   // DUT inputs
   logic               rvvi;
   logic               arstN_i;
   logic               rvfiValid_i;
   orderT              rvfiOrder_i;
   xlenT               rvfiInsn_i, rvfiPcRdata_i, rvfiPcWdata_i, rvfiRdWdata_i;
   privModeT           rvfiMode_i;
   logic               rvfiTrap_i, rvfiTrapException_i;
   excCauseT           rvfiExcCause_i;
   logic               rvfiIntr_i, rvfiIntrInterrupt_i;
   intrCauseT          rvfiIntrCause_i;
   dbgCauseT           rvfiDbgCause_i;
   logic               rvfiDbgMode_i, rvfiNmiPending_i;
   regAddrT            rvfiRdAddr_i;
   xlenT [NUM_CSR-1:0] csrRdata_i, csrWdata_i, csrWmask_i;
   logic [NUM_IRQ-1:0] irq_i;

   // DUT outputs
   logic               rvviValid_o, rvviTrap_o, rvviIntr_o;
   orderT              rvviOrder_o;
   xlenT               rvviInsn_o, rvviPcRdata_o, rvviPcWdata_o, xWdata_o;
   privModeT           rvviMode_o;
   logic [NUM_GPR-1:0] xWb_o;
   xlenT [NUM_CSR-1:0] csrValue_o;
   logic [NUM_CSR-1:0] csrWb_o;
   logic               haltReq_o, nmi_o, fetchFault_o;
   intrCauseT          nmiCause_o;
   logic [NUM_IRQ-1:0] irqLevel_o, irqChange_o;
   logic [3:0]         netChange_o;

   integer seed = 55890;
   int     errCount = 0;
   int     checkCount = 0;

`include "rvviModel.svh"

   rvviBridge #(.NUM_CSR(NUM_CSR), .NUM_IRQ(NUM_IRQ)) i_dut (.*);

   always begin
      rvvi = 1'b0;
      #10;
      rvvi = 1'b1;
      #10;
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////
   task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
      checkCount++;
      assert (got === exp) else begin
         errCount++;
         $display("error %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   // Everything that must sit at zero while reset is held
   task automatic checkReset();
      checkValue("rvviValid_o", 64'(rvviValid_o), 64'd0);
      checkValue("rvviTrap_o", 64'(rvviTrap_o), 64'd0);
      checkValue("xWb_o", 64'(xWb_o), 64'd0);
      checkValue("csrWb_o", 64'(csrWb_o), 64'd0);
      checkValue("haltReq_o", 64'(haltReq_o), 64'd0);
      checkValue("nmi_o", 64'(nmi_o), 64'd0);
      checkValue("nmiCause_o", 64'(nmiCause_o), 64'd0);
      checkValue("fetchFault_o", 64'(fetchFault_o), 64'd0);
      checkValue("irqLevel_o", 64'(irqLevel_o), 64'd0);
      checkValue("netChange_o", 64'(netChange_o), 64'd0);
      checkValue("irqChange_o", 64'(irqChange_o), 64'd0);
   endtask

   task automatic checkOutputs();
      checkValue("rvviValid_o", 64'(rvviValid_o), 64'(expValid));
      if (expValid) begin
         checkValue("rvviOrder_o", rvviOrder_o, curRec.order);
         checkValue("rvviInsn_o", 64'(rvviInsn_o), 64'(curRec.insn));
         checkValue("rvviPcRdata_o", 64'(rvviPcRdata_o), 64'(curRec.pcRdata));
         checkValue("rvviPcWdata_o", 64'(rvviPcWdata_o), 64'(curRec.pcWdata));
         checkValue("rvviMode_o", 64'(rvviMode_o), 64'(curRec.mode));
         checkValue("rvviTrap_o", 64'(rvviTrap_o), 64'(curRec.trap));
         checkValue("rvviIntr_o", 64'(rvviIntr_o), 64'(curRec.intr));
         checkValue("xWb_o", 64'(xWb_o), 64'(curRec.xWb));
         checkValue("xWdata_o", 64'(xWdata_o), 64'(curRec.xWdata));
         for (int i = 0; i < NUM_CSR; i++) begin
            checkValue($sformatf("csrValue_o[%0d]", i), 64'(csrValue_o[i]),
                       64'(curRec.csrValue[i]));
            checkValue($sformatf("csrWb_o[%0d]", i), 64'(csrWb_o[i]), 64'(curRec.csrWb[i]));
         end
      end
      checkValue("haltReq_o", 64'(haltReq_o), 64'(expHalt));
      checkValue("nmi_o", 64'(nmi_o), 64'(expNmi));
      checkValue("nmiCause_o", 64'(nmiCause_o), 64'(expNmiCause));
      checkValue("fetchFault_o", 64'(fetchFault_o), 64'(expFault));
      // Bit 3 halt, bit 2 NMI, bit 1 NMI cause, bit 0 fetch fault
      checkValue("netChange_o", 64'(netChange_o),
                 64'({expHalt ^ prevHalt, expNmi ^ prevNmi,
                      expNmiCause != prevCause, expFault ^ prevFault}));
      checkValue("irqLevel_o", 64'(irqLevel_o), 64'(expIrq));
      checkValue("irqChange_o", 64'(irqChange_o), 64'(expIrq ^ expIrqPrev));
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////
   task automatic initInputs();
      arstN_i             = 1'b0;
      rvfiValid_i         = 1'b0;
      rvfiOrder_i         = '0;
      rvfiInsn_i          = '0;
      rvfiPcRdata_i       = '0;
      rvfiPcWdata_i       = '0;
      rvfiRdWdata_i       = '0;
      rvfiMode_i          = '0;
      rvfiTrap_i          = 1'b0;
      rvfiTrapException_i = 1'b0;
      rvfiExcCause_i      = '0;
      rvfiIntr_i          = 1'b0;
      rvfiIntrInterrupt_i = 1'b0;
      rvfiIntrCause_i     = '0;
      rvfiDbgCause_i      = '0;
      rvfiDbgMode_i       = 1'b0;
      rvfiNmiPending_i    = 1'b0;
      rvfiRdAddr_i        = '0;
      csrRdata_i          = '0;
      csrWdata_i          = '0;
      csrWmask_i          = '0;
      irq_i               = '0;
   endtask

   // Causes are drawn from small sets so fetch faults, NMIs and halts come up often
   task automatic driveRandom();
      rvfiValid_i = (($random(seed) & 3) != 0);
      if (($random(seed) & 3) != 0) begin
         rvfiOrder_i = rvfiOrder_i + 64'd1;
      end
      rvfiInsn_i          = $random(seed);
      rvfiPcRdata_i       = $random(seed);
      rvfiPcWdata_i       = $random(seed);
      rvfiMode_i          = 2'($random(seed));
      rvfiTrap_i          = 1'($random(seed));
      rvfiTrapException_i = 1'($random(seed));
      case ($random(seed) & 3)
         0, 1:    rvfiExcCause_i = 6'd48;
         2:       rvfiExcCause_i = 6'd2;
         default: rvfiExcCause_i = 6'($random(seed));
      endcase
      rvfiIntr_i          = 1'($random(seed));
      rvfiIntrInterrupt_i = 1'($random(seed));
      case ($random(seed) & 3)
         0:       rvfiIntrCause_i = 11'd1024;
         1:       rvfiIntrCause_i = 11'd1025;
         2:       rvfiIntrCause_i = 11'd7;
         default: rvfiIntrCause_i = 11'($random(seed));
      endcase
      rvfiDbgCause_i   = (($random(seed) & 1) != 0) ? 3'd3 : 3'($random(seed));
      rvfiDbgMode_i    = 1'($random(seed));
      rvfiNmiPending_i = (($random(seed) & 7) == 0);
      rvfiRdAddr_i     = (($random(seed) & 3) == 0) ? 5'd0 : 5'($random(seed));
      rvfiRdWdata_i    = $random(seed);
      // About half the CSRs keep their trace words, so some merges repeat
      for (int i = 0; i < NUM_CSR; i++) begin
         if (($random(seed) & 1) != 0) begin
            csrRdata_i[i] = $random(seed);
            csrWdata_i[i] = $random(seed);
            csrWmask_i[i] = $random(seed);
         end
      end
      if (($random(seed) & 3) == 0) begin
         irq_i = $random(seed);
      end
   endtask

   // One clock cycle with the model at the edge, drive shortly after and check at the falling edge
   task automatic runCycle(input bit active);
      @(posedge rvvi);
      modelEdge();
      #1;
      if (active) begin
         driveRandom();
      end else begin
         rvfiValid_i = 1'b0;
      end
      @(negedge rvvi);
      checkOutputs();
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////
   initial begin
      int drainCycles;
      initInputs();
      // Inputs keep moving while reset is held
      repeat (3) begin
         @(posedge rvvi);
         #1;
         checkReset();
         driveRandom();
      end
      arstN_i = 1'b1;

      for (int c = 0; c < NUM_ITER; c++) begin
         runCycle(1'b1);
      end

      // Let the last accepted retirements come out
      drainCycles = 0;
      while ((recQ.size() > 0 || drainCycles < 2) && drainCycles < DRAIN_MAX) begin
         runCycle(1'b0);
         drainCycles++;
      end
      assert (recQ.size() == 0) else begin
         errCount++;
         $display("timeout while draining: %0d expected records never appeared", recQ.size());
      end

      $display("checks %0d, records %0d, errors %0d", checkCount, recCount, errCount);
      if (errCount == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* rvviBridge.f */
+incdir+tb
common/rvviPkg.sv
common/retireIf.sv
verilog/rvfiCapture.sv
csrTrack/csrMerge.sv
verilog/faultEvents.sv
verilog/rvviOutput.sv
verilog/rvviBridge.sv
tb/tbRvviBridge.sv

/* build.sh */
#!/bin/sh
# Compile the testbench and the bridge with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   -f rvviBridge.f \
   --top-module tbRvviBridge \
   -o tbRvviBridge

./obj_dir/tbRvviBridge | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
   echo "simulation run passed"
   exit 0
else
   echo "simulation run failed, see sim.log"
   exit 1
fi
